// ==== bench/conv_trace.txt ====
# Records: L load start, C <coef>, P <pix0> <pix1> <pix2>, R <expected sum>,
# X restart, G <0|1> random idle gaps before beats; all values signed decimal
# First filter set, coefficients 0 to 8 in window order
L C 3 C -1 C 2 C 5 C 0 C -4 C 1 C 7 C -2
# Single window
P 10 20 30 P -5 4 6 P 7 -8 9 R 235
# Back to back windows
P 1 2 3 P 4 5 6 P 7 8 9 R 18
P -100 50 25 P 0 0 1000 P 300 -2 1 R 7581
P 131071 -131072 1 P 2 2 2 P 0 0 0 R -262134
# Random idle gaps
G 1
P 10 20 30 P -5 4 6 P 7 -8 9 R 235
P 1 2 3 P 4 5 6 P 7 8 9 R 18
# Partial window dropped by a restart
P 5 5 5 P 6 6 6 X
P -100 50 25 P 0 0 1000 P 300 -2 1 R 7581
# Second filter set loaded from RUN
G 0
L C -3 C 2 C 4 C 1 C -1 C 6 C 0 C 5 C -7
P 10 20 30 P -5 4 6 P 7 -8 9 R -77
P 1 2 3 P 4 5 6 P 7 8 9 R 45

// ==== all.f ====
logic/conv_pkg.sv
logic/delay_line.sv
logic/phase_counter.sv
logic/conv_control.sv
logic/macc_slice.sv
logic/conv_array.sv
logic/conv_engine.sv
bench/conv_engine_properties.sv
bench/tb_conv_engine.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_conv_engine
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_conv_engine.sv ====
`timescale 1ns/1ps

module tb_conv_engine
    import conv_pkg::*;
();

    localparam string TRACE_FILE  = "bench/conv_trace.txt";
    localparam int    DRAIN_LIMIT = 64;

    logic     clk;
    logic     rst;
    logic     i_load_start;
    coef_t    i_coef;
    logic     i_coef_valid;
    pix_vec_t i_pix;
    logic     i_pix_valid;
    logic     i_restart;
    logic     o_ready;
    result_t  o_result;
    logic     o_result_valid;

    // Expected results and the cycle each one is due
    result_t     exp_value [$];
    int          exp_due [$];
    int          edge_cnt = 0;
    bit          ready_exp;
    int          coef_seen;
    int          beat_idx;
    int          last_beat_cycle;
    bit          gaps_on;
    logic [15:0] lfsr;

    conv_engine i_conv_engine (
        .clk            (clk),
        .rst            (rst),
        .i_load_start   (i_load_start),
        .i_coef         (i_coef),
        .i_coef_valid   (i_coef_valid),
        .i_pix          (i_pix),
        .i_pix_valid    (i_pix_valid),
        .i_restart      (i_restart),
        .o_ready        (o_ready),
        .o_result       (o_result),
        .o_result_valid (o_result_valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks and helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_result(input string name, input result_t got, input result_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input bit got, input bit exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    // Ends one cycle, checks outputs mid-cycle, then clears the strobes
    task automatic tick();
        @(negedge clk);
        check_flag("o_ready", o_ready, ready_exp);
        if (exp_due.size() > 0 && exp_due[0] == edge_cnt) begin
            check_flag("o_result_valid", o_result_valid, 1'b1);
            check_result("o_result", o_result, exp_value[0]);
            void'(exp_due.pop_front());
            void'(exp_value.pop_front());
        end else begin
            check_flag("o_result_valid", o_result_valid, 1'b0);
        end
        i_load_start = 1'b0;
        i_coef_valid = 1'b0;
        i_pix_valid  = 1'b0;
        i_restart    = 1'b0;
    endtask

    task automatic drive_beat(input int p0, input int p1, input int p2);
        int gap;
        if (gaps_on) begin
            draw_bits(2, gap);
            repeat (gap) begin
                tick();
            end
        end
        tick();
        i_pix[0]    = pix_t'(p0);
        i_pix[1]    = pix_t'(p1);
        i_pix[2]    = pix_t'(p2);
        i_pix_valid = 1'b1;
        beat_idx    = beat_idx + 1;
        if (beat_idx == NUM_SLICES) begin
            beat_idx        = 0;
            last_beat_cycle = edge_cnt;
        end
    endtask

    task automatic skip_line(input int fd);
        int code;
        code = $fgetc(fd);
        while (code != -1 && code != 10) begin
            code = $fgetc(fd);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Trace replay
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int  fd;
        int  code;
        byte ch;
        int  v0;
        int  v1;
        int  v2;
        int  waited;

        rst          = 1'b1;
        i_load_start = 1'b0;
        i_coef       = '0;
        i_coef_valid = 1'b0;
        i_pix        = '0;
        i_pix_valid  = 1'b0;
        i_restart    = 1'b0;
        ready_exp    = 1'b0;
        coef_seen    = 0;
        beat_idx     = 0;
        gaps_on      = 1'b0;
        lfsr         = 16'd81;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            fail_run("could not open the trace file bench/conv_trace.txt");
        end
        code = $fgetc(fd);
        while (code != -1) begin
            ch = byte'(code);
            case (ch)
                "#": skip_line(fd);
                "L": begin
                    tick();
                    i_load_start = 1'b1;
                    ready_exp    = 1'b0;
                    coef_seen    = 0;
                end
                "C": begin
                    if ($fscanf(fd, "%d", v0) != 1) begin
                        fail_run("trace has a C record without a value");
                    end
                    tick();
                    i_coef       = coef_t'(v0);
                    i_coef_valid = 1'b1;
                    // Junk beat that the engine must ignore while loading
                    i_pix        = '1;
                    i_pix_valid  = 1'b1;
                    coef_seen    = coef_seen + 1;
                    if (coef_seen == TAPS) begin
                        ready_exp = 1'b1;
                    end
                end
                "P": begin
                    if ($fscanf(fd, "%d %d %d", v0, v1, v2) != 3) begin
                        fail_run("trace has a P record without three pixels");
                    end
                    drive_beat(v0, v1, v2);
                end
                "R": begin
                    if ($fscanf(fd, "%d", v0) != 1) begin
                        fail_run("trace has an R record without a value");
                    end
                    exp_value.push_back(result_t'(v0));
                    exp_due.push_back(last_beat_cycle + RESULT_LATENCY);
                end
                "X": begin
                    tick();
                    i_restart = 1'b1;
                    beat_idx  = 0;
                end
                "G": begin
                    if ($fscanf(fd, "%d", v0) != 1) begin
                        fail_run("trace has a G record without a value");
                    end
                    gaps_on = (v0 != 0);
                end
                default: begin
                end
            endcase
            code = $fgetc(fd);
        end
        $fclose(fd);

        // Wait for the last results
        waited = 0;
        while (exp_due.size() > 0) begin
            if (waited >= DRAIN_LIMIT) begin
                fail_run("timed out waiting for pending results");
            end else begin
                tick();
                waited = waited + 1;
            end
        end
        // Quiet tail with no strobes expected
        repeat (8) begin
            tick();
        end

        $display("sim passed");
        $finish;
    end

endmodule

// ==== bench/conv_engine_properties.sv ====
`timescale 1ns/1ps

module conv_engine_properties (
    input logic clk,
    input logic rst,
    input logic i_load_start,
    input logic i_coef_valid,
    input logic i_ready,
    input logic i_result_valid
);

    // No result strobe straight out of reset
    a_quiet_after_reset: assert property (@(posedge clk)
        $past(rst) |-> !i_result_valid)
        else $error("result valid in the cycle after reset");

    // Engine closed while the banks fill
    a_closed_on_coef: assert property (@(posedge clk) disable iff (rst)
        i_coef_valid |-> !i_ready)
        else $error("ready high during a coefficient strobe");

    a_closed_after_load: assert property (@(posedge clk) disable iff (rst)
        i_load_start |=> !i_ready)
        else $error("ready still high after a load start");

    // At most one finished window every three beats
    a_result_spacing: assert property (@(posedge clk) disable iff (rst)
        i_result_valid |-> !$past(i_result_valid) && !$past(i_result_valid, 2))
        else $error("result strobes closer than three cycles");

endmodule

bind conv_engine conv_engine_properties u_properties (
    .clk            (clk),
    .rst            (rst),
    .i_load_start   (i_load_start),
    .i_coef_valid   (i_coef_valid),
    .i_ready        (o_ready),
    .i_result_valid (o_result_valid)
);

// ==== logic/conv_engine.sv ====
`timescale 1ns/1ps

module conv_engine
    import conv_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     i_load_start,
    input  coef_t    i_coef,
    input  logic     i_coef_valid,
    input  pix_vec_t i_pix,
    input  logic     i_pix_valid,
    input  logic     i_restart,
    output logic     o_ready,
    output result_t  o_result,
    output logic     o_result_valid
);

    logic [NUM_SLICES-1:0] bank_shift;
    logic                  active;
    logic                  beat;
    bank_sel_t             phase;
    logic                  last;

    conv_control u_control (
        .clk          (clk),
        .rst          (rst),
        .i_load_start (i_load_start),
        .i_coef_valid (i_coef_valid),
        .o_bank_shift (bank_shift),
        .o_active     (active)
    );

    // Steps on each counted beat from the array
    phase_counter u_phase (
        .clk       (clk),
        .rst       (rst),
        .i_step    (beat),
        .i_restart (i_restart),
        .o_phase   (phase),
        .o_last    (last)
    );

    conv_array u_array (
        .clk            (clk),
        .rst            (rst),
        .i_bank_shift   (bank_shift),
        .i_coef         (i_coef),
        .i_active       (active),
        .i_pix_valid    (i_pix_valid),
        .i_pix          (i_pix),
        .i_phase        (phase),
        .i_last         (last),
        .o_beat         (beat),
        .o_result       (o_result),
        .o_result_valid (o_result_valid)
    );

    assign o_ready = active;

endmodule

// ==== logic/conv_array.sv ====
`timescale 1ns/1ps

module conv_array
    import conv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [NUM_SLICES-1:0] i_bank_shift,
    input  coef_t                 i_coef,
    input  logic                  i_active,
    input  logic                  i_pix_valid,
    input  pix_vec_t              i_pix,
    input  bank_sel_t             i_phase,
    input  logic                  i_last,
    output logic                  o_beat,
    output result_t               o_result,
    output logic                  o_result_valid
);

    logic       beat;
    logic       first_beat;
    logic       last_beat;
    logic [1:0] accum_in;
    logic [1:0] accum_out;
    logic       accum;
    logic       accum_clr;
    result_t    cascade [NUM_SLICES];
    result_t    sums    [NUM_SLICES];

    ////////////////////////////////////////////////////////////////////////////
    // Beat qualification
    ////////////////////////////////////////////////////////////////////////////

    // Beats only count while the engine is running
    assign beat       = i_pix_valid && i_active;
    assign first_beat = beat && (i_phase == PHASE_FIRST);
    assign last_beat  = beat && i_last;
    assign o_beat     = beat;

    ////////////////////////////////////////////////////////////////////////////
    // Accumulate and result timing
    ////////////////////////////////////////////////////////////////////////////

    // Arrives with the beat's sum at the last slice
    // The first-beat bit also covers windows dropped by a restart
    assign accum_in = {first_beat, beat};

    delay_line #(.T(logic [1:0]), .DEPTH(ACCUM_DELAY)) u_accum_dly (
        .clk    (clk),
        .rst    (rst),
        .i_data (accum_in),
        .o_data (accum_out)
    );

    assign accum     = accum_out[0];
    assign accum_clr = accum_out[1];

    // High in the cycle the last slice holds the full window
    delay_line #(.T(bit), .DEPTH(RESULT_LATENCY)) u_valid_dly (
        .clk    (clk),
        .rst    (rst),
        .i_data (last_beat),
        .o_data (o_result_valid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Slice cascade
    ////////////////////////////////////////////////////////////////////////////

    generate
        for (genvar d = 0; d < NUM_SLICES; d++) begin : g_slice
            if (d == 0) begin : g_head
                assign cascade[d] = '0;
            end else begin : g_link
                assign cascade[d] = sums[d-1];
            end

            macc_slice #(
                .SLICE    (d),
                .IS_ACCUM (d == NUM_SLICES - 1)
            ) u_slice (
                .clk         (clk),
                .rst         (rst),
                .i_shift     (i_bank_shift[d]),
                .i_coef      (i_coef),
                .i_sel       (i_phase),
                .i_pix       (i_pix[d]),
                .i_accum     (accum),
                .i_accum_clr (accum_clr),
                .i_cascade   (cascade[d]),
                .o_sum       (sums[d])
            );
        end
    endgenerate

    assign o_result = sums[NUM_SLICES-1];

endmodule

// ==== logic/macc_slice.sv ====
`timescale 1ns/1ps

module macc_slice
    import conv_pkg::*;
#(
    parameter int SLICE    = 0,
    parameter bit IS_ACCUM = 1'b0
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      i_shift,
    input  coef_t     i_coef,
    input  bank_sel_t i_sel,
    input  pix_t      i_pix,
    input  logic      i_accum,
    input  logic      i_accum_clr,
    input  result_t   i_cascade,
    output result_t   o_sum
);

    coef_t   bank [NUM_SLICES];
    coef_t   coef_sel;
    coef_t   coef_d;
    pix_t    pix_d;
    result_t product;

    // First loaded coefficient ends up at the top entry of the bank
    always_ff @(posedge clk) begin
        if (i_shift) begin
            bank[0] <= i_coef;
            for (int k = 1; k < NUM_SLICES; k++) begin
                bank[k] <= bank[k-1];
            end
        end
    end

    // Picked on the beat itself so a reload cannot disturb beats in flight
    assign coef_sel = bank[i_sel];

    delay_line #(.T(pix_t), .DEPTH(SLICE + 1)) u_pix_dly (
        .clk    (clk),
        .rst    (rst),
        .i_data (i_pix),
        .o_data (pix_d)
    );

    delay_line #(.T(coef_t), .DEPTH(SLICE + 1)) u_coef_dly (
        .clk    (clk),
        .rst    (rst),
        .i_data (coef_sel),
        .o_data (coef_d)
    );

    always_ff @(posedge clk) begin
        product <= result_t'(pix_d) * result_t'(coef_d);
    end

    generate
        if (IS_ACCUM) begin : g_accum
            // Holds between beats, restarts from zero on a window's first beat
            always_ff @(posedge clk) begin
                if (i_accum) begin
                    o_sum <= (i_accum_clr ? result_t'(0) : o_sum) + product + i_cascade;
                end
            end
        end else begin : g_cascade
            always_ff @(posedge clk) begin
                o_sum <= product + i_cascade;
            end
        end
    endgenerate

endmodule

// ==== logic/conv_control.sv ====
`timescale 1ns/1ps

module conv_control
    import conv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_load_start,
    input  logic                  i_coef_valid,
    output logic [NUM_SLICES-1:0] o_bank_shift,
    output logic                  o_active
);

    ctrl_state_t state;
    ctrl_state_t state_next;
    coef_cnt_t   coef_cnt;
    coef_cnt_t   coef_cnt_next;
    logic        coef_take;
    bank_sel_t   bank_idx;

    ////////////////////////////////////////////////////////////////////////////
    // Load and run FSM
    ////////////////////////////////////////////////////////////////////////////

    // A fresh load start in LOAD drops the strobe and restarts the count
    assign coef_take = (state == LOAD) && i_coef_valid && !i_load_start;

    always_comb begin
        state_next    = state;
        coef_cnt_next = coef_cnt;
        case (state)
            IDLE, RUN: begin
                if (i_load_start) begin
                    state_next    = LOAD;
                    coef_cnt_next = '0;
                end
            end
            LOAD: begin
                if (i_load_start) begin
                    coef_cnt_next = '0;
                end else if (coef_take) begin
                    if (coef_cnt == COEF_LAST) begin
                        state_next    = RUN;
                        coef_cnt_next = '0;
                    end else begin
                        coef_cnt_next = coef_cnt + 1'b1;
                    end
                end
            end
            default: begin
                state_next    = IDLE;
                coef_cnt_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            coef_cnt <= '0;
        end else begin
            state    <= state_next;
            coef_cnt <= coef_cnt_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bank steering
    ////////////////////////////////////////////////////////////////////////////

    // Coefficients 0-2 go to bank 0, 3-5 to bank 1, 6-8 to bank 2
    assign bank_idx = bank_sel_t'(coef_cnt / coef_cnt_t'(NUM_SLICES));

    always_comb begin
        for (int d = 0; d < NUM_SLICES; d++) begin
            o_bank_shift[d] = coef_take && (bank_idx == bank_sel_t'(d));
        end
    end

    assign o_active = (state == RUN);

endmodule

// ==== logic/phase_counter.sv ====
`timescale 1ns/1ps

module phase_counter
    import conv_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      i_step,
    input  logic      i_restart,
    output bank_sel_t o_phase,
    output logic      o_last
);

    ////////////////////////////////////////////////////////////////////////////
    // Beat position within a window
    ////////////////////////////////////////////////////////////////////////////

    // Runs 2, 1, 0 and wraps; restart takes priority over a step
    always_ff @(posedge clk) begin
        if (rst) begin
            o_phase <= PHASE_FIRST;
        end else if (i_restart) begin
            o_phase <= PHASE_FIRST;
        end else if (i_step) begin
            if (o_phase == '0) begin
                o_phase <= PHASE_FIRST;
            end else begin
                o_phase <= o_phase - 1'b1;
            end
        end
    end

    // Third beat of the window
    assign o_last = (o_phase == '0);

endmodule

// ==== logic/delay_line.sv ====
`timescale 1ns/1ps

module delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic rst,
    input  T     i_data,
    output T     o_data
);

    // Stage 0 takes the input, last stage drives the output
    T stages [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= T'(0);
            end
        end else begin
            stages[0] <= i_data;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign o_data = stages[DEPTH-1];

endmodule

// ==== logic/conv_pkg.sv ====
package conv_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Window geometry
    ////////////////////////////////////////////////////////////////////////////

    // One slice per window column, one beat per window row
    localparam int NUM_SLICES = 3;
    localparam int TAPS       = NUM_SLICES * NUM_SLICES;

    // DSP style operand and accumulator widths
    localparam int DATA_W   = 18;
    localparam int RESULT_W = 48;

    // Coefficient counter during a filter load
    localparam int COEF_CNT_W = $clog2(TAPS);

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline timing
    ////////////////////////////////////////////////////////////////////////////

    // Beat to last slice sum register, and third beat to result strobe
    localparam int ACCUM_DELAY    = NUM_SLICES + 1;
    localparam int RESULT_LATENCY = NUM_SLICES + 2;

    ////////////////////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic signed [DATA_W-1:0]   pix_t;
    typedef logic signed [DATA_W-1:0]   coef_t;
    typedef pix_t        [NUM_SLICES-1:0] pix_vec_t;
    typedef logic signed [RESULT_W-1:0] result_t;

    // Filter bank entry and window phase
    typedef logic [1:0] bank_sel_t;

    typedef logic [COEF_CNT_W-1:0] coef_cnt_t;

    // Phase of the first beat, entry of the first loaded coefficient
    localparam bank_sel_t PHASE_FIRST = bank_sel_t'(NUM_SLICES - 1);
    localparam coef_cnt_t COEF_LAST   = coef_cnt_t'(TAPS - 1);

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        RUN
    } ctrl_state_t;

endpackage
